/* dv/pmu_trace.txt */
# op addr data expect cycles, all hex except cycles
# W data, expect bresp; R data is rdata, expect rresp; cycles 1 takes the response at once
# E data is the event pattern for cycles edges; Q and O expect level within cycles
R 00 00000000 0 0
W 00 00000001 0 0
R 00 00000001 0 0
E 00 00000015 0 7
R 04 00000007 0 0
R 08 00000000 0 0
R 14 00000007 0 0
R 24 00000000 0 0
W 00 00000000 0 0
E 00 000001FF 0 5
R 04 00000007 0 0
W 00 00000002 0 0
W 00 00000000 0 0
R 0C 00000000 0 0
# Bus rules
R 38 00000000 2 0
R FC 00000000 2 0
W 2C 00000001 2 0
W 3C 00000001 2 0
R 2C 00000000 0 0
W 28 FFFFFFFF 0 0
R 28 000001FF 0 0
W 28 00000000 0 0
W 34 12345678 0 0
R 34 12345678 0 0
# Self-test, two unstalled cfg writes around 10 idle cycles span 14 edges
W 00 40000001 0 1
E 00 00000000 0 10
W 00 40000000 0 1
R 04 0000000E 0 0
R 24 0000000E 0 0
W 00 80000001 0 1
E 00 000001FF 0 10
W 00 80000000 0 1
R 18 0000000E 0 0
W 00 00000002 0 0
W 00 C0000001 0 1
E 00 000001FE 0 10
W 00 C0000000 0 1
R 04 0000000E 0 0
R 08 00000000 0 0
R 00 C0000000 0 0
# Overflow, counter 3 masked in, counter 6 masked out
W 00 00000004 0 0
W 28 00000008 0 0
W 1C FFFFFFFF 0 0
R 1C FFFFFFFF 0 0
W 00 00000005 0 0
E 00 00000040 0 1
W 00 00000004 0 0
R 1C 00000000 0 0
R 2C 00000040 0 0
O 00 00000000 0 4
W 10 FFFFFFFF 0 0
W 00 00000005 0 0
E 00 00000008 0 1
W 00 00000004 0 0
R 10 00000000 0 0
R 2C 00000048 0 0
O 00 00000000 1 4
W 00 0000000C 0 0
W 00 00000004 0 0
R 2C 00000000 0 0
O 00 00000000 0 4
# Quota, counters 0 and 1 against a limit of 16
W 00 00000002 0 0
W 00 00000000 0 0
W 34 00000010 0 0
W 30 00000003 0 0
R 30 00000003 0 0
W 00 00000001 0 0
E 00 00000007 0 8
Q 00 00000000 0 20
E 00 00000004 0 5
Q 00 00000000 0 20
E 00 00000002 0 1
Q 00 00000000 1 20
W 00 00000000 0 0
W 34 FFFFFFFF 0 0
Q 00 00000000 1 20
W 00 00000010 0 0
W 00 00000000 0 0
Q 00 00000000 0 20
R 08 00000009 0 0
R 0C 0000000D 0 0

/* build.f */
verilog/pmu_pkg.sv
verilog/pmu_axil_regs.sv
verilog/pmu_counters.sv
verilog/pmu_overflow.sv
verilog/pmu_quota.sv
verilog/pmu_top.sv
dv/tb_pmu.sv

/* Makefile */
# Verilator build and run of the PMU testbench

VERILATOR ?= verilator
TOP       ?= tb_pmu
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@if grep -q "Test failed" $(LOG); then \
		echo "FAIL, see $(LOG)"; exit 1; \
	elif grep -q "Test completed successfully" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL, no result in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/tb_pmu.sv */
//----------------------------------------
// PMU testbench
// Replays the operation trace against the
// PMU top level over AXI4-Lite, drives the
// event inputs and checks read data,
// response codes and both interrupts
//----------------------------------------
module tb_pmu;
    timeunit 1ns;
    timeprecision 1ps;

    import pmu_pkg::*;

    // Trace file path from the project root
    localparam string TRACE_PATH = "dv/pmu_trace.txt";
    // Watchdog budget per trace operation
    localparam int CYCLES_PER_OP = 200;

    logic       clk_i;
    logic       rst_i;
    axil_req_t  req;
    axil_rsp_t  rsp;
    event_vec_t events;
    logic       intr_overflow;
    logic       intr_quota;

    integer seed;
    int     trace_ops;

    pmu_top DUT (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .axil_i          (req),
        .events_i        (events),
        .axil_o          (rsp),
        .intr_overflow_o (intr_overflow),
        .intr_quota_o    (intr_quota)
    );

    // 20 ns period
    always #10 clk_i = ~clk_i;

    //----------------------------------------
    // Failure reporting and compare tasks
    //----------------------------------------
    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_data(input counter_t got, input counter_t exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("error at %0t: %s got %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_resp(input logic [1:0] got, input logic [1:0] exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("error at %0t: %s got %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic check_intr(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("error at %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    // Ready about three cycles out of four
    function automatic logic ready_draw();
        logic [31:0] r;
        r = $random(seed);
        return r[1:0] != 2'b00;
    endfunction

    //----------------------------------------
    // Bus and event drivers
    //----------------------------------------
    task automatic bus_write(input logic [ADDR_WIDTH-1:0] addr, input counter_t data,
                             input logic [1:0] exp_resp, input logic no_stall);
        @(posedge clk_i);
        req.awaddr <= addr;
        req.awvalid <= 1'b1;
        req.wdata <= data;
        req.wstrb <= '1;
        req.wvalid <= 1'b1;
        @(negedge clk_i);
        while (!rsp.awready) @(negedge clk_i);
        // Address and data channels accept together
        if (!rsp.wready) begin
            stop_run($sformatf("Write data at %h was not accepted with its address", addr));
        end
        // Handshake at this edge
        @(posedge clk_i);
        req.awvalid <= 1'b0;
        req.wvalid <= 1'b0;
        req.bready <= no_stall || ready_draw();
        @(negedge clk_i);
        while (!(rsp.bvalid && req.bready)) begin
            @(posedge clk_i);
            req.bready <= no_stall || ready_draw();
            @(negedge clk_i);
        end
        check_resp(rsp.bresp, exp_resp, $sformatf("write response at %h", addr));
        @(posedge clk_i);
        req.bready <= 1'b0;
        // Response taken so bvalid must be low now
        @(negedge clk_i);
        if (rsp.bvalid) begin
            stop_run($sformatf("Write response at %h was delivered twice", addr));
        end
    endtask

    task automatic bus_read(input logic [ADDR_WIDTH-1:0] addr, input counter_t exp_data,
                            input logic [1:0] exp_resp, input logic no_stall);
        @(posedge clk_i);
        req.araddr <= addr;
        req.arvalid <= 1'b1;
        @(negedge clk_i);
        while (!rsp.arready) @(negedge clk_i);
        @(posedge clk_i);
        req.arvalid <= 1'b0;
        req.rready <= no_stall || ready_draw();
        @(negedge clk_i);
        while (!(rsp.rvalid && req.rready)) begin
            @(posedge clk_i);
            req.rready <= no_stall || ready_draw();
            @(negedge clk_i);
        end
        check_data(rsp.rdata, exp_data, $sformatf("read data at %h", addr));
        check_resp(rsp.rresp, exp_resp, $sformatf("read response at %h", addr));
        @(posedge clk_i);
        req.rready <= 1'b0;
        @(negedge clk_i);
        if (rsp.rvalid) begin
            stop_run($sformatf("Read response at %h was delivered twice", addr));
        end
    endtask

    // Pattern seen at exactly cycles rising edges
    task automatic drive_events(input event_vec_t pattern, input int cycles);
        @(posedge clk_i);
        events <= pattern;
        repeat (cycles) @(posedge clk_i);
        events <= '0;
    endtask

    // Expected high must rise within the bound and then stay up
    // Expected low must hold for the whole bound
    task automatic wait_intr(input logic is_quota, input logic exp, input int bound);
        logic  level;
        logic  seen;
        string name;
        name = is_quota ? "quota interrupt" : "overflow interrupt";
        level = 1'b0;
        seen = 1'b0;
        repeat (bound) begin
            @(negedge clk_i);
            level = is_quota ? intr_quota : intr_overflow;
            if (!exp) begin
                check_intr(level, 1'b0, name);
            end else if (seen && !level) begin
                stop_run($sformatf("The %s dropped before its soft reset", name));
            end
            seen = seen || level;
        end
        check_intr(seen, exp, name);
    endtask

    //----------------------------------------
    // Trace reading
    //----------------------------------------
    task automatic skip_line(input int fd);
        int ch;
        ch = $fgetc(fd);
        while (ch != "\n" && ch != -1) ch = $fgetc(fd);
    endtask

    task automatic count_ops(output int n);
        int          fd;
        int          code;
        logic [7:0]  op;
        n = 0;
        fd = $fopen(TRACE_PATH, "r");
        if (fd == 0) stop_run("Cannot open the trace file");
        code = $fscanf(fd, " %c", op);
        while (code == 1) begin
            if (op != "#") n++;
            skip_line(fd);
            code = $fscanf(fd, " %c", op);
        end
        $fclose(fd);
    endtask

    // Watchdog sized by the trace length
    initial begin
        wait (trace_ops > 0);
        repeat (trace_ops * CYCLES_PER_OP) @(posedge clk_i);
        stop_run($sformatf("Watchdog expired, the trace did not finish in %0d cycles",
                           trace_ops * CYCLES_PER_OP));
    end

    //----------------------------------------
    // Main sequence
    //----------------------------------------
    initial begin
        int                    fd;
        int                    code;
        int                    ops;
        logic [7:0]            op;
        logic [ADDR_WIDTH-1:0] addr;
        counter_t              data;
        logic [31:0]           expv;
        int                    cyc;
        clk_i = 1'b0;
        rst_i = 1'b1;
        req = '0;
        events = '0;
        seed = 32'h9289;
        count_ops(ops);
        trace_ops = ops;
        repeat (3) @(posedge clk_i);
        rst_i <= 1'b0;
        fd = $fopen(TRACE_PATH, "r");
        if (fd == 0) stop_run("Cannot open the trace file");
        code = $fscanf(fd, " %c", op);
        while (code == 1) begin
            if (op == "#") begin
                skip_line(fd);
            end else begin
                if ($fscanf(fd, "%h %h %h %d", addr, data, expv, cyc) != 4) begin
                    stop_run("Malformed line in the trace file");
                end
                skip_line(fd);
                case (op)
                    "W": bus_write(addr, data, expv[1:0], cyc != 0);
                    "R": bus_read(addr, data, expv[1:0], cyc != 0);
                    "E": drive_events(data[N_COUNTERS-1:0], cyc);
                    "Q": wait_intr(1'b1, expv[0], cyc);
                    "O": wait_intr(1'b0, expv[0], cyc);
                    default: stop_run($sformatf("Unknown operation %c in the trace", op));
                endcase
            end
            code = $fscanf(fd, " %c", op);
        end
        $fclose(fd);
        $display("Test completed successfully");
        $finish;
    end

endmodule

/* verilog/pmu_top.sv */
//----------------------------------------
// PMU top level
// AXI4-Lite register file, event counter
// bank and the overflow and quota monitors
//----------------------------------------
module pmu_top (
    input  logic                clk_i,
    input  logic                rst_i,
    input  pmu_pkg::axil_req_t  axil_i,
    input  pmu_pkg::event_vec_t events_i,
    output pmu_pkg::axil_rsp_t  axil_o,
    output logic                intr_overflow_o,
    output logic                intr_quota_o
);
    import pmu_pkg::*;

    // Register file to datapath
    pmu_cfg_t   cfg;
    cnt_load_t  cnt_load;
    event_vec_t ovf_mask;
    event_vec_t quota_mask;
    counter_t   quota_limit;

    // Datapath back to register file and monitors
    counter_arr_t counters;
    event_vec_t   wrapped;
    event_vec_t   ovf_vect;

    //----------------------------------------
    // Bus slave and registers
    //----------------------------------------
    pmu_axil_regs u_regs (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .axil_i        (axil_i),
        .counters_i    (counters),
        .ovf_vect_i    (ovf_vect),
        .axil_o        (axil_o),
        .cfg_o         (cfg),
        .cnt_load_o    (cnt_load),
        .ovf_mask_o    (ovf_mask),
        .quota_mask_o  (quota_mask),
        .quota_limit_o (quota_limit)
    );

    // Event counters
    pmu_counters u_counters (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .cfg_i      (cfg),
        .cnt_load_i (cnt_load),
        .events_i   (events_i),
        .counters_o (counters),
        .wrapped_o  (wrapped)
    );

    //----------------------------------------
    // Monitors
    //----------------------------------------
    pmu_overflow u_overflow (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .wrapped_i       (wrapped),
        .ovf_enable_i    (cfg.ovf_enable),
        .ovf_softrst_i   (cfg.ovf_softrst),
        .ovf_mask_i      (ovf_mask),
        .ovf_vect_o      (ovf_vect),
        .intr_overflow_o (intr_overflow_o)
    );

    pmu_quota u_quota (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .counters_i      (counters),
        .quota_mask_i    (quota_mask),
        .quota_limit_i   (quota_limit),
        .quota_softrst_i (cfg.quota_softrst),
        .intr_quota_o    (intr_quota_o)
    );

endmodule

/* verilog/pmu_quota.sv */
//----------------------------------------
// PMU quota monitor
// Walks the counters one per cycle, sums
// the masked ones and compares the total
// with the limit once per round
//----------------------------------------
module pmu_quota (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  pmu_pkg::counter_arr_t counters_i,
    input  pmu_pkg::event_vec_t   quota_mask_i,
    input  pmu_pkg::counter_t     quota_limit_i,
    input  logic                  quota_softrst_i,
    output logic                  intr_quota_o
);
    import pmu_pkg::*;

    // Steps 0..N_COUNTERS-1 add, step N_COUNTERS compares
    logic [QUOTA_STEP_WIDTH-1:0] step_q;
    // One extra bit for the carry of the sum
    logic [REG_WIDTH:0]          sum_q;
    logic                        intr_q;
    logic                        cmp_step;
    counter_t                    addend;

    //----------------------------------------
    // Current counter contribution
    //----------------------------------------
    always_comb begin
        cmp_step = (step_q == QUOTA_STEP_WIDTH'(N_COUNTERS));
        addend = '0;
        if (!cmp_step && quota_mask_i[step_q]) begin
            addend = counters_i[step_q];
        end
    end

    //----------------------------------------
    // Walker, accumulator and sticky flag
    //----------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i || quota_softrst_i) begin
            step_q <= '0;
            sum_q <= '0;
            intr_q <= 1'b0;
        end else if (cmp_step) begin
            // End of round, restart from counter 0
            step_q <= '0;
            sum_q <= '0;
            if (sum_q > {1'b0, quota_limit_i}) begin
                intr_q <= 1'b1;
            end
        end else begin
            step_q <= step_q + 1'b1;
            sum_q <= sum_q + (REG_WIDTH + 1)'(addend);
        end
    end

    assign intr_quota_o = intr_q;

endmodule

/* verilog/pmu_overflow.sv */
//----------------------------------------
// PMU overflow monitor
// Sticky record of wrapped counters and
// the registered, masked interrupt
//----------------------------------------
module pmu_overflow (
    input  logic                clk_i,
    input  logic                rst_i,
    input  pmu_pkg::event_vec_t wrapped_i,
    input  logic                ovf_enable_i,
    input  logic                ovf_softrst_i,
    input  pmu_pkg::event_vec_t ovf_mask_i,
    output pmu_pkg::event_vec_t ovf_vect_o,
    output logic                intr_overflow_o
);
    import pmu_pkg::*;

    event_vec_t vect_q;
    logic       intr_q;

    //----------------------------------------
    // Sticky overflow vector
    //----------------------------------------
    // Bits only set while enabled, cleared by soft reset
    always_ff @(posedge clk_i) begin
        if (rst_i || ovf_softrst_i) begin
            vect_q <= '0;
        end else if (ovf_enable_i) begin
            vect_q <= vect_q | wrapped_i;
        end
    end

    //----------------------------------------
    // Interrupt
    //----------------------------------------
    // Follows the masked vector one cycle later
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            intr_q <= 1'b0;
        end else begin
            intr_q <= |(vect_q & ovf_mask_i);
        end
    end

    assign ovf_vect_o = vect_q;
    assign intr_overflow_o = intr_q;

endmodule

/* verilog/pmu_counters.sv */
//----------------------------------------
// PMU event counter bank
// Picks events from the inputs or a
// self-test pattern, counts them, applies
// bus loads and soft reset, flags wraps
//----------------------------------------
module pmu_counters (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  pmu_pkg::pmu_cfg_t     cfg_i,
    input  pmu_pkg::cnt_load_t    cnt_load_i,
    input  pmu_pkg::event_vec_t   events_i,
    output pmu_pkg::counter_arr_t counters_o,
    output pmu_pkg::event_vec_t   wrapped_o
);
    import pmu_pkg::*;

    event_vec_t   ev_sel;
    event_vec_t   load_hit;
    event_vec_t   step;
    counter_arr_t cnt_q;

    //----------------------------------------
    // Self-test event selection
    //----------------------------------------
    always_comb begin
        case (cfg_i.selftest)
            SELFTEST_OFF:     ev_sel = events_i;
            SELFTEST_ALL_ON:  ev_sel = '1;
            SELFTEST_ALL_OFF: ev_sel = '0;
            // Only event 0 stays high
            SELFTEST_ONE_ON:  ev_sel = {{(N_COUNTERS-1){1'b0}}, 1'b1};
            default:          ev_sel = events_i;
        endcase
    end

    //----------------------------------------
    // Per counter step decision
    //----------------------------------------
    always_comb begin
        for (int i = 0; i < N_COUNTERS; i++) begin
            load_hit[i] = cnt_load_i.valid && (cnt_load_i.idx == CNT_IDX_WIDTH'(i));
            // Load and soft reset both beat counting
            step[i] = cfg_i.enable && ev_sel[i] && !load_hit[i] && !cfg_i.softrst;
            // All ones about to roll over to zero
            wrapped_o[i] = step[i] && (cnt_q[i] == '1);
        end
    end

    //----------------------------------------
    // Counter registers
    //----------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i || cfg_i.softrst) begin
            cnt_q <= '0;
        end else begin
            for (int i = 0; i < N_COUNTERS; i++) begin
                if (load_hit[i]) begin
                    cnt_q[i] <= cnt_load_i.data;
                end else if (step[i]) begin
                    cnt_q[i] <= cnt_q[i] + 1'b1;
                end
            end
        end
    end

    assign counters_o = cnt_q;

endmodule

/* verilog/pmu_axil_regs.sv */
//----------------------------------------
// PMU AXI4-Lite register file
// Slave for both bus channels, holds the
// configuration, mask and limit registers,
// turns counter writes into load requests
// and multiplexes read data
//----------------------------------------
module pmu_axil_regs (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  pmu_pkg::axil_req_t    axil_i,
    input  pmu_pkg::counter_arr_t counters_i,
    input  pmu_pkg::event_vec_t   ovf_vect_i,
    output pmu_pkg::axil_rsp_t    axil_o,
    output pmu_pkg::pmu_cfg_t     cfg_o,
    output pmu_pkg::cnt_load_t    cnt_load_o,
    output pmu_pkg::event_vec_t   ovf_mask_o,
    output pmu_pkg::event_vec_t   quota_mask_o,
    output pmu_pkg::counter_t     quota_limit_o
);
    import pmu_pkg::*;

    // Software visible registers
    logic [REG_WIDTH-1:0] cfg_q;
    event_vec_t           ovf_mask_q;
    event_vec_t           quota_mask_q;
    counter_t             quota_limit_q;

    // Write channel state
    logic                      bvalid_q;
    logic [1:0]                bresp_q;
    logic [WORD_IDX_WIDTH-1:0] wr_idx;
    logic                      wr_fire;
    logic                      wr_is_cnt;
    logic                      wr_ok;

    // Pending counter load
    logic                     load_valid_q;
    logic [CNT_IDX_WIDTH-1:0] load_idx_q;
    counter_t                 load_data_q;

    // Read channel state
    logic                      rvalid_q;
    logic [1:0]                rresp_q;
    logic [REG_WIDTH-1:0]      rdata_q;
    logic [WORD_IDX_WIDTH-1:0] rd_idx;
    logic                      rd_fire;
    logic                      rd_ok;
    logic [REG_WIDTH-1:0]      rd_word;

    // Word index falls in the counter window
    function automatic logic is_counter(input logic [WORD_IDX_WIDTH-1:0] idx);
        return (idx >= REG_COUNTER_BASE) && (idx <= REG_COUNTER_LAST);
    endfunction

    //----------------------------------------
    // Write channel
    //----------------------------------------
    assign wr_idx = axil_i.awaddr[ADDR_WIDTH-1:2];
    // Address and data taken together, one response at a time
    assign wr_fire = axil_i.awvalid && axil_i.wvalid && !bvalid_q;
    assign wr_is_cnt = is_counter(wr_idx);
    // Overflow vector is read only
    assign wr_ok = wr_is_cnt || (wr_idx == REG_CFG) || (wr_idx == REG_OVF_MASK)
                || (wr_idx == REG_QUOTA_MASK) || (wr_idx == REG_QUOTA_LIMIT);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cfg_q <= '0;
            ovf_mask_q <= '0;
            quota_mask_q <= '0;
            quota_limit_q <= '0;
            bvalid_q <= 1'b0;
            load_valid_q <= 1'b0;
        end else begin
            // Load strobe lives for the cycle after the handshake
            load_valid_q <= wr_fire && wr_is_cnt;
            if (wr_fire) begin
                bvalid_q <= 1'b1;
                case (wr_idx)
                    REG_CFG:         cfg_q <= axil_i.wdata;
                    REG_OVF_MASK:    ovf_mask_q <= axil_i.wdata[N_COUNTERS-1:0];
                    REG_QUOTA_MASK:  quota_mask_q <= axil_i.wdata[N_COUNTERS-1:0];
                    REG_QUOTA_LIMIT: quota_limit_q <= axil_i.wdata;
                    default: ;
                endcase
            end else if (axil_i.bready) begin
                bvalid_q <= 1'b0;
            end
        end
    end

    // Response code and load payload
    always_ff @(posedge clk_i) begin
        if (wr_fire) begin
            bresp_q <= wr_ok ? RESP_OKAY : RESP_SLVERR;
            load_idx_q <= CNT_IDX_WIDTH'(wr_idx - REG_COUNTER_BASE);
            load_data_q <= axil_i.wdata;
        end
    end

    //----------------------------------------
    // Read channel
    //----------------------------------------
    assign rd_idx = axil_i.araddr[ADDR_WIDTH-1:2];
    assign rd_fire = axil_i.arvalid && !rvalid_q;

    // Current register state, zero for holes
    always_comb begin
        rd_word = '0;
        rd_ok = 1'b1;
        if (is_counter(rd_idx)) begin
            rd_word = counters_i[CNT_IDX_WIDTH'(rd_idx - REG_COUNTER_BASE)];
        end else begin
            case (rd_idx)
                REG_CFG:         rd_word = cfg_q;
                REG_OVF_MASK:    rd_word = REG_WIDTH'(ovf_mask_q);
                REG_OVF_VECT:    rd_word = REG_WIDTH'(ovf_vect_i);
                REG_QUOTA_MASK:  rd_word = REG_WIDTH'(quota_mask_q);
                REG_QUOTA_LIMIT: rd_word = quota_limit_q;
                default:         rd_ok = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rvalid_q <= 1'b0;
        end else if (rd_fire) begin
            rvalid_q <= 1'b1;
        end else if (axil_i.rready) begin
            rvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_fire) begin
            rdata_q <= rd_word;
            rresp_q <= rd_ok ? RESP_OKAY : RESP_SLVERR;
        end
    end

    //----------------------------------------
    // Outputs
    //----------------------------------------
    always_comb begin
        axil_o.awready = wr_fire;
        axil_o.wready = wr_fire;
        axil_o.bresp = bresp_q;
        axil_o.bvalid = bvalid_q;
        axil_o.arready = !rvalid_q;
        axil_o.rdata = rdata_q;
        axil_o.rresp = rresp_q;
        axil_o.rvalid = rvalid_q;
    end

    // Configuration fields
    always_comb begin
        cfg_o.enable = cfg_q[CFG_EN_BIT];
        cfg_o.softrst = cfg_q[CFG_SOFTRST_BIT];
        cfg_o.ovf_enable = cfg_q[CFG_OVF_EN_BIT];
        cfg_o.ovf_softrst = cfg_q[CFG_OVF_SOFTRST_BIT];
        cfg_o.quota_softrst = cfg_q[CFG_QUOTA_SOFTRST_BIT];
        cfg_o.selftest = selftest_e'(cfg_q[CFG_SELFTEST_LSB +: 2]);
    end

    assign cnt_load_o.valid = load_valid_q;
    assign cnt_load_o.idx = load_idx_q;
    assign cnt_load_o.data = load_data_q;
    assign ovf_mask_o = ovf_mask_q;
    assign quota_mask_o = quota_mask_q;
    assign quota_limit_o = quota_limit_q;

endmodule

/* verilog/pmu_pkg.sv */
//----------------------------------------
// PMU shared definitions
// Register map, configuration bit positions,
// AXI4-Lite channel structs and the internal
// counter, load and configuration types
//----------------------------------------
package pmu_pkg;

    //----------------------------------------
    // Sizes
    //----------------------------------------
    localparam int REG_WIDTH = 32;
    localparam int N_COUNTERS = 9;
    localparam int ADDR_WIDTH = 8;
    // Byte address minus the two offset bits
    localparam int WORD_IDX_WIDTH = ADDR_WIDTH - 2;
    // Index of one counter
    localparam int CNT_IDX_WIDTH = $clog2(N_COUNTERS);
    // Quota walker also needs one extra compare step
    localparam int QUOTA_STEP_WIDTH = $clog2(N_COUNTERS + 1);

    //----------------------------------------
    // Register map, word indexes
    //----------------------------------------
    localparam logic [WORD_IDX_WIDTH-1:0] REG_CFG = 6'd0;
    localparam logic [WORD_IDX_WIDTH-1:0] REG_COUNTER_BASE = 6'd1;
    localparam logic [WORD_IDX_WIDTH-1:0] REG_COUNTER_LAST =
        WORD_IDX_WIDTH'(REG_COUNTER_BASE + N_COUNTERS - 1);
    localparam logic [WORD_IDX_WIDTH-1:0] REG_OVF_MASK = 6'd10;
    // Read only, written by hardware
    localparam logic [WORD_IDX_WIDTH-1:0] REG_OVF_VECT = 6'd11;
    localparam logic [WORD_IDX_WIDTH-1:0] REG_QUOTA_MASK = 6'd12;
    localparam logic [WORD_IDX_WIDTH-1:0] REG_QUOTA_LIMIT = 6'd13;

    // Configuration register bits
    localparam int CFG_EN_BIT = 0;
    localparam int CFG_SOFTRST_BIT = 1;
    localparam int CFG_OVF_EN_BIT = 2;
    localparam int CFG_OVF_SOFTRST_BIT = 3;
    localparam int CFG_QUOTA_SOFTRST_BIT = 4;
    // Two bit self-test field at 31:30
    localparam int CFG_SELFTEST_LSB = 30;

    // Self-test event sources
    typedef enum logic [1:0] {
        SELFTEST_OFF     = 2'b00,
        SELFTEST_ALL_ON  = 2'b01,
        SELFTEST_ALL_OFF = 2'b10,
        SELFTEST_ONE_ON  = 2'b11
    } selftest_e;

    // AXI response codes
    localparam logic [1:0] RESP_OKAY = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    //----------------------------------------
    // Types
    //----------------------------------------
    // One bit per counter, also masks and overflow vector
    typedef logic [N_COUNTERS-1:0] event_vec_t;
    typedef logic [REG_WIDTH-1:0] counter_t;
    typedef counter_t [N_COUNTERS-1:0] counter_arr_t;

    // Decoded configuration register
    typedef struct packed {
        logic      enable;
        logic      softrst;
        logic      ovf_enable;
        logic      ovf_softrst;
        logic      quota_softrst;
        selftest_e selftest;
    } pmu_cfg_t;

    // Counter write from the bus
    typedef struct packed {
        logic                     valid;
        logic [CNT_IDX_WIDTH-1:0] idx;
        counter_t                 data;
    } cnt_load_t;

    // Master to slave
    typedef struct packed {
        logic [ADDR_WIDTH-1:0]  awaddr;
        logic                   awvalid;
        logic [REG_WIDTH-1:0]   wdata;
        logic [REG_WIDTH/8-1:0] wstrb;
        logic                   wvalid;
        logic                   bready;
        logic [ADDR_WIDTH-1:0]  araddr;
        logic                   arvalid;
        logic                   rready;
    } axil_req_t;

    // Slave to master
    typedef struct packed {
        logic                 awready;
        logic                 wready;
        logic [1:0]           bresp;
        logic                 bvalid;
        logic                 arready;
        logic [REG_WIDTH-1:0] rdata;
        logic [1:0]           rresp;
        logic                 rvalid;
    } axil_rsp_t;

endpackage
